// File: design/msu_pkg.sv
package msu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths fixed by the register map
  ////////////////////////////////////////////////////////////
  localparam int MSU_BUF_AW       = 14;
  localparam int MSU_SEEK_W       = 32;
  localparam int MSU_TRACK_W      = 16;
  localparam int MSU_STATUS_W     = 6;
  localparam int MSU_STATUS_OUT_W = 7;

  // Read side register indices
  localparam logic [2:0] MSU_REG_STATUS = 3'd0;
  localparam logic [2:0] MSU_REG_DATA   = 3'd1;

  // Write side register indices
  localparam logic [2:0] MSU_REG_SEEK0  = 3'd0;
  localparam logic [2:0] MSU_REG_SEEK1  = 3'd1;
  localparam logic [2:0] MSU_REG_SEEK2  = 3'd2;
  localparam logic [2:0] MSU_REG_SEEK3  = 3'd3;
  localparam logic [2:0] MSU_REG_TRACK0 = 3'd4;
  localparam logic [2:0] MSU_REG_TRACK1 = 3'd5;
  localparam logic [2:0] MSU_REG_VOLUME = 3'd6;
  localparam logic [2:0] MSU_REG_CTRL   = 3'd7;

  // "S-MSU1", first character at register 2
  localparam logic [47:0] MSU_ID_STRING = 48'h53_2D_4D_53_55_31;
  localparam logic [2:0]  MSU_REVISION  = 3'b001;
  localparam logic [MSU_BUF_AW-1:0] MSU_PTR_RESET = 14'h1234;

  ////////////////////////////////////////////////////////////
  // Bit positions in the set/reset masks
  ////////////////////////////////////////////////////////////
  localparam int MSU_ST_AUDIO_BUSY   = 5;
  localparam int MSU_ST_DATA_BUSY    = 4;
  localparam int MSU_ST_AUDIO_ERROR  = 3;
  localparam int MSU_ST_AUDIO_STATUS = 1;  // low bit of the 2-bit field
  localparam int MSU_ST_CTRL_START   = 0;

  // Synchronizer history lengths
  localparam int MSU_ENABLE_DEPTH = 5;
  localparam int MSU_STROBE_DEPTH = 6;

endpackage

// File: design/msu_bus_sync.sv
`timescale 1ns/1ns

module msu_bus_sync (
  input  logic       clkin,
  input  logic       rst,
  input  logic       enable,
  input  logic [2:0] reg_addr,
  input  logic       reg_oe,
  input  logic       reg_we,
  output logic       reg_rd_rise,
  output logic       reg_wr_rise,
  output logic [2:0] reg_addr_d1,
  output logic [2:0] reg_addr_d3
);

  import msu_pkg::*;

  logic [MSU_ENABLE_DEPTH-1:0] enable_hist;
  logic [MSU_STROBE_DEPTH-1:0] oe_hist;
  logic [MSU_STROBE_DEPTH-1:0] we_hist;
  logic [2:0]                  addr_q [0:3];
  logic                        enable_ok;

  ////////////////////////////////////////////////////////////
  // Strobe and enable histories
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (rst) begin
      enable_hist <= '0;
      oe_hist     <= '0;
      we_hist     <= '0;
    end else begin
      enable_hist <= {enable_hist[MSU_ENABLE_DEPTH-2:0], enable};
      oe_hist     <= {oe_hist[MSU_STROBE_DEPTH-2:0], reg_oe};
      we_hist     <= {we_hist[MSU_STROBE_DEPTH-2:0], reg_we};
    end
  end

  // Address delay line, stage 0 is the newest sample
  always_ff @(posedge clkin) begin
    addr_q[0] <= reg_addr;
    addr_q[1] <= addr_q[0];
    addr_q[2] <= addr_q[1];
    addr_q[3] <= addr_q[2];
  end

  assign enable_ok = enable_hist[MSU_ENABLE_DEPTH-1];

  // A single new high after a full run of lows counts as an edge
  assign reg_rd_rise = enable_ok && (oe_hist == {{(MSU_STROBE_DEPTH-1){1'b0}}, 1'b1});
  assign reg_wr_rise = enable_ok && (we_hist == {{(MSU_STROBE_DEPTH-1){1'b0}}, 1'b1});

  assign reg_addr_d1 = addr_q[1];
  assign reg_addr_d3 = addr_q[3];

endmodule

// File: design/msu_databuf.sv
`timescale 1ns/1ns

module msu_databuf (
  input  logic                          clkin,
  input  logic                          pgm_we,
  input  logic [msu_pkg::MSU_BUF_AW-1:0] pgm_address,
  input  logic [7:0]                    pgm_data,
  input  logic [msu_pkg::MSU_BUF_AW-1:0] read_ptr,
  output logic [7:0]                    buf_data
);

  import msu_pkg::*;

  logic [7:0] mem [0:(2**MSU_BUF_AW)-1];

  // Microcontroller port, writes every clock while pgm_we is low
  always_ff @(posedge clkin) begin
    if (!pgm_we) begin
      mem[pgm_address] <= pgm_data;
    end
  end

  // CPU port, one cycle read latency
  always_ff @(posedge clkin) begin
    buf_data <= mem[read_ptr];
  end

endmodule

// File: design/msu_regs.sv
`timescale 1ns/1ns

module msu_regs (
  input  logic                                clkin,
  input  logic                                rst,
  input  logic                                reg_rd_rise,
  input  logic                                reg_wr_rise,
  input  logic [2:0]                          reg_addr_d1,
  input  logic [2:0]                          reg_addr_d3,
  input  logic [7:0]                          reg_data_in,
  input  logic [7:0]                          buf_data,
  input  logic [msu_pkg::MSU_STATUS_W-1:0]     status_set_bits,
  input  logic [msu_pkg::MSU_STATUS_W-1:0]     status_reset_bits,
  input  logic                                status_reset_we,
  input  logic [msu_pkg::MSU_BUF_AW-1:0]       msu_address_ext,
  input  logic                                msu_address_ext_write,
  output logic [7:0]                          reg_data_out,
  output logic [msu_pkg::MSU_BUF_AW-1:0]       read_ptr,
  output logic [msu_pkg::MSU_STATUS_OUT_W-1:0] status_out,
  output logic [msu_pkg::MSU_SEEK_W-1:0]       addr_out,
  output logic [msu_pkg::MSU_TRACK_W-1:0]      track_out,
  output logic [7:0]                          volume_out,
  output logic                                volume_latch_out
);

  import msu_pkg::*;

  logic [1:0] status_we_q;
  logic [1:0] ext_write_q;
  logic       status_upd;
  logic       ext_load;

  logic       data_start;
  logic       data_busy;
  logic       audio_start;
  logic       audio_busy;
  logic       audio_error;
  logic [1:0] audio_status;
  logic [1:0] audio_ctrl;
  logic       ctrl_start;

  ////////////////////////////////////////////////////////////
  // Microcontroller strobe edge detection
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (rst) begin
      status_we_q <= 2'b00;
      ext_write_q <= 2'b00;
    end else begin
      status_we_q <= {status_we_q[0], status_reset_we};
      ext_write_q <= {ext_write_q[0], msu_address_ext_write};
    end
  end

  assign status_upd = (status_we_q == 2'b01);
  assign ext_load   = (ext_write_q == 2'b01);

  // Seek, track and volume bytes
  always_ff @(posedge clkin) begin
    if (reg_wr_rise) begin
      case (reg_addr_d1)
        MSU_REG_SEEK0:  addr_out[7:0]   <= reg_data_in;
        MSU_REG_SEEK1:  addr_out[15:8]  <= reg_data_in;
        MSU_REG_SEEK2:  addr_out[23:16] <= reg_data_in;
        MSU_REG_SEEK3:  addr_out[31:24] <= reg_data_in;
        MSU_REG_TRACK0: track_out[7:0]  <= reg_data_in;
        MSU_REG_TRACK1: track_out[15:8] <= reg_data_in;
        MSU_REG_VOLUME: volume_out      <= reg_data_in;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Start, busy and status flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (rst) begin
      data_start       <= 1'b0;
      data_busy        <= 1'b1;
      audio_start      <= 1'b0;
      audio_busy       <= 1'b1;
      audio_error      <= 1'b0;
      audio_status     <= 2'b00;
      audio_ctrl       <= 2'b00;
      ctrl_start       <= 1'b0;
      volume_latch_out <= 1'b0;
    end else if (reg_wr_rise) begin
      case (reg_addr_d1)
        MSU_REG_SEEK3: begin
          data_start <= 1'b1;
          data_busy  <= 1'b1;
        end
        MSU_REG_TRACK1: begin
          audio_start <= 1'b1;
          audio_busy  <= 1'b1;
        end
        MSU_REG_VOLUME: volume_latch_out <= 1'b1;
        MSU_REG_CTRL: begin
          // Ignored while a track is still loading
          if (!audio_busy) begin
            audio_ctrl <= reg_data_in[1:0];
            ctrl_start <= 1'b1;
          end
        end
        default: ;
      endcase
    end else if (status_upd) begin
      audio_busy <= (audio_busy | status_set_bits[MSU_ST_AUDIO_BUSY])
                    & ~status_reset_bits[MSU_ST_AUDIO_BUSY];
      if (status_reset_bits[MSU_ST_AUDIO_BUSY]) begin
        audio_start <= 1'b0;
      end
      data_busy <= (data_busy | status_set_bits[MSU_ST_DATA_BUSY])
                   & ~status_reset_bits[MSU_ST_DATA_BUSY];
      if (status_reset_bits[MSU_ST_DATA_BUSY]) begin
        data_start <= 1'b0;
      end
      audio_error <= (audio_error | status_set_bits[MSU_ST_AUDIO_ERROR])
                     & ~status_reset_bits[MSU_ST_AUDIO_ERROR];
      audio_status <= (audio_status | status_set_bits[MSU_ST_AUDIO_STATUS +: 2])
                      & ~status_reset_bits[MSU_ST_AUDIO_STATUS +: 2];
      ctrl_start <= (ctrl_start | status_set_bits[MSU_ST_CTRL_START])
                    & ~status_reset_bits[MSU_ST_CTRL_START];
    end else begin
      volume_latch_out <= 1'b0;
    end
  end

  // Read pointer, external load wins over auto-increment
  always_ff @(posedge clkin) begin
    if (rst) begin
      read_ptr <= MSU_PTR_RESET;
    end else if (ext_load) begin
      read_ptr <= msu_address_ext;
    end else if (reg_rd_rise && reg_addr_d3 == MSU_REG_DATA) begin
      read_ptr <= read_ptr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // CPU read data
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    case (reg_addr_d1)
      MSU_REG_STATUS: reg_data_out <= {data_busy, audio_busy, audio_status,
                                       audio_error, MSU_REVISION};
      MSU_REG_DATA:   reg_data_out <= buf_data;
      default:        reg_data_out <= MSU_ID_STRING[8 * (7 - reg_addr_d1) +: 8];
    endcase
  end

  assign status_out = {read_ptr[MSU_BUF_AW-1], audio_start, data_start,
                       volume_latch_out, audio_ctrl, ctrl_start};

endmodule

// File: design/msu_top.sv
`timescale 1ns/1ns

module msu_top (
  input  logic                                clkin,
  input  logic                                rst,
  input  logic                                enable,
  input  logic [2:0]                          reg_addr,
  input  logic [7:0]                          reg_data_in,
  output logic [7:0]                          reg_data_out,
  input  logic                                reg_oe,
  input  logic                                reg_we,
  input  logic [msu_pkg::MSU_BUF_AW-1:0]       pgm_address,
  input  logic [7:0]                          pgm_data,
  input  logic                                pgm_we,
  input  logic [msu_pkg::MSU_STATUS_W-1:0]     status_set_bits,
  input  logic [msu_pkg::MSU_STATUS_W-1:0]     status_reset_bits,
  input  logic                                status_reset_we,
  input  logic [msu_pkg::MSU_BUF_AW-1:0]       msu_address_ext,
  input  logic                                msu_address_ext_write,
  output logic [msu_pkg::MSU_STATUS_OUT_W-1:0] status_out,
  output logic [msu_pkg::MSU_SEEK_W-1:0]       addr_out,
  output logic [msu_pkg::MSU_TRACK_W-1:0]      track_out,
  output logic [7:0]                          volume_out,
  output logic                                volume_latch_out
);

  import msu_pkg::*;

  logic                  reg_rd_rise;
  logic                  reg_wr_rise;
  logic [2:0]            reg_addr_d1;
  logic [2:0]            reg_addr_d3;
  logic [MSU_BUF_AW-1:0] read_ptr;
  logic [7:0]            buf_data;

  ////////////////////////////////////////////////////////////
  // CPU bus front end
  ////////////////////////////////////////////////////////////
  msu_bus_sync u_bus_sync (
    .clkin(clkin), .rst(rst), .enable(enable), .reg_addr(reg_addr),
    .reg_oe(reg_oe), .reg_we(reg_we), .reg_rd_rise(reg_rd_rise),
    .reg_wr_rise(reg_wr_rise), .reg_addr_d1(reg_addr_d1), .reg_addr_d3(reg_addr_d3)
  );

  msu_regs u_regs (
    .clkin(clkin), .rst(rst), .reg_rd_rise(reg_rd_rise), .reg_wr_rise(reg_wr_rise),
    .reg_addr_d1(reg_addr_d1), .reg_addr_d3(reg_addr_d3), .reg_data_in(reg_data_in),
    .buf_data(buf_data), .status_set_bits(status_set_bits),
    .status_reset_bits(status_reset_bits), .status_reset_we(status_reset_we),
    .msu_address_ext(msu_address_ext), .msu_address_ext_write(msu_address_ext_write),
    .reg_data_out(reg_data_out), .read_ptr(read_ptr), .status_out(status_out),
    .addr_out(addr_out), .track_out(track_out), .volume_out(volume_out),
    .volume_latch_out(volume_latch_out)
  );

  // Data buffer shared with the microcontroller
  msu_databuf u_databuf (
    .clkin(clkin), .pgm_we(pgm_we), .pgm_address(pgm_address),
    .pgm_data(pgm_data), .read_ptr(read_ptr), .buf_data(buf_data)
  );

endmodule

// File: tb/msu_tb_checks.svh
`ifndef MSU_TB_CHECKS_SVH
`define MSU_TB_CHECKS_SVH

// Step to the drive point just after a rising edge
task automatic wait_cycles(input int n);
  repeat (n) begin
    @(posedge clkin);
    #DRIVE_DELAY;
  end
endtask

////////////////////////////////////////////////////////////
// Bus and microcontroller accesses
////////////////////////////////////////////////////////////
task automatic cpu_write(input logic [2:0] idx, input logic [7:0] data);
  int i;
  reg_addr    = idx;
  reg_data_in = data;
  wait_cycles(2);
  reg_we       = 1'b1;
  latch_pulses = 8'd0;
  // Strobe held for three samples, then the idle gap
  for (i = 0; i < IDLE_CYCLES + 3; i++) begin
    wait_cycles(1);
    if (i == 2) begin
      reg_we = 1'b0;
    end
    if (volume_latch_out) begin
      latch_pulses = latch_pulses + 8'd1;
    end
  end
endtask

task automatic cpu_read(input logic [2:0] idx, output logic [7:0] data);
  reg_addr = idx;
  // Long enough for the three-edge address delay to settle
  wait_cycles(4);
  reg_oe = 1'b1;
  wait_cycles(2);
  data   = reg_data_out;
  reg_oe = 1'b0;
  wait_cycles(IDLE_CYCLES);
endtask

task automatic status_update(input logic [5:0] set_mask, input logic [5:0] reset_mask);
  status_set_bits   = set_mask;
  status_reset_bits = reset_mask;
  status_reset_we   = 1'b1;
  wait_cycles(3);
  status_reset_we   = 1'b0;
  status_set_bits   = '0;
  status_reset_bits = '0;
  wait_cycles(6);
endtask

task automatic pointer_load(input logic [MSU_BUF_AW-1:0] addr);
  msu_address_ext       = addr;
  msu_address_ext_write = 1'b1;
  wait_cycles(3);
  msu_address_ext_write = 1'b0;
  wait_cycles(6);
endtask

task automatic buffer_fill(input logic [MSU_BUF_AW-1:0] start, input logic [7:0] count);
  int i;
  logic [MSU_BUF_AW-1:0] addr;
  logic [31:0] word;
  for (i = 0; i < int'(count); i++) begin
    addr            = start + i[MSU_BUF_AW-1:0];
    word            = $random(seed);
    buf_model[addr] = word[7:0];
    pgm_address     = addr;
    pgm_data        = word[7:0];
    pgm_we          = 1'b0;
    wait_cycles(1);
  end
  pgm_we = 1'b1;
  wait_cycles(1);
endtask

////////////////////////////////////////////////////////////
// Typed compares
////////////////////////////////////////////////////////////
task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
  if (act !== exp) begin
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_status(input string name, input logic [MSU_STATUS_OUT_W-1:0] exp,
                            input logic [MSU_STATUS_OUT_W-1:0] act);
  if (act !== exp) begin
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_seek(input string name, input logic [MSU_SEEK_W-1:0] exp,
                          input logic [MSU_SEEK_W-1:0] act);
  if (act !== exp) begin
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_track(input string name, input logic [MSU_TRACK_W-1:0] exp,
                           input logic [MSU_TRACK_W-1:0] act);
  if (act !== exp) begin
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

`endif

// File: tb/msu_tb.sv
`timescale 1ns/1ns

module msu_tb;

  import msu_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 8;
  localparam int STEP_CYCLES  = 20;

  // Bus spacing from the synchronizer depths
  localparam int IDLE_CYCLES   = MSU_STROBE_DEPTH + 2;
  localparam int SETTLE_CYCLES = MSU_ENABLE_DEPTH + 3;

  // Output selectors for check steps
  localparam logic [MSU_BUF_AW-1:0] SEL_STATUS = 14'd0;
  localparam logic [MSU_BUF_AW-1:0] SEL_ADDR   = 14'd1;
  localparam logic [MSU_BUF_AW-1:0] SEL_TRACK  = 14'd2;
  localparam logic [MSU_BUF_AW-1:0] SEL_VOLUME = 14'd3;
  localparam logic [MSU_BUF_AW-1:0] SEL_LATCH  = 14'd4;
  localparam logic [MSU_BUF_AW-1:0] SEL_PULSES = 14'd5;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_STATUS, OP_LOAD, OP_FILL, OP_CHECK} op_t;

  typedef struct {
    op_t                   op;
    logic [MSU_BUF_AW-1:0] index;  // register, buffer address or output selector
    logic [7:0]            data;   // write byte or fill length
    logic [5:0]            set_mask;
    logic [5:0]            reset_mask;
    logic [31:0]           expected;
  } step_t;

  logic                          clkin;
  logic                          rst;
  logic                          enable;
  logic [2:0]                    reg_addr;
  logic [7:0]                    reg_data_in;
  logic [7:0]                    reg_data_out;
  logic                          reg_oe;
  logic                          reg_we;
  logic [MSU_BUF_AW-1:0]         pgm_address;
  logic [7:0]                    pgm_data;
  logic                          pgm_we;
  logic [MSU_STATUS_W-1:0]       status_set_bits;
  logic [MSU_STATUS_W-1:0]       status_reset_bits;
  logic                          status_reset_we;
  logic [MSU_BUF_AW-1:0]         msu_address_ext;
  logic                          msu_address_ext_write;
  logic [MSU_STATUS_OUT_W-1:0]   status_out;
  logic [MSU_SEEK_W-1:0]         addr_out;
  logic [MSU_TRACK_W-1:0]        track_out;
  logic [7:0]                    volume_out;
  logic                          volume_latch_out;

  step_t                 steps[$];
  logic [7:0]            buf_model [0:(2**MSU_BUF_AW)-1];
  logic [MSU_BUF_AW-1:0] model_ptr = 14'h1234;
  logic [7:0]            latch_pulses = 8'd0;
  logic                  table_ready = 1'b0;
  integer                seed;

  msu_top uut (.*);

  `include "msu_tb_checks.svh"

  initial begin
    clkin = 1'b0;
    forever #(CLK_PERIOD / 2) clkin = ~clkin;
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "stopping at the first error");
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////
  task automatic build_table();
    // Reset state
    steps.push_back(step_t'{OP_CHECK,  SEL_STATUS, 8'h00, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_CHECK,  SEL_LATCH,  8'h00, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_READ,   14'd0,      8'h00, 6'h00, 6'h00, 32'hC1});
    // Seek and track
    steps.push_back(step_t'{OP_STATUS, 14'd0,      8'h00, 6'h00, 6'h30, 32'h00});
    steps.push_back(step_t'{OP_READ,   14'd0,      8'h00, 6'h00, 6'h00, 32'h01});
    steps.push_back(step_t'{OP_WRITE,  14'd0,      8'h78, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_WRITE,  14'd1,      8'h56, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_WRITE,  14'd2,      8'h34, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_WRITE,  14'd3,      8'h12, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_CHECK,  SEL_ADDR,   8'h00, 6'h00, 6'h00, 32'h12345678});
    steps.push_back(step_t'{OP_CHECK,  SEL_STATUS, 8'h00, 6'h00, 6'h00, 32'h10});
    steps.push_back(step_t'{OP_WRITE,  14'd4,      8'hCD, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_WRITE,  14'd5,      8'hAB, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_CHECK,  SEL_TRACK,  8'h00, 6'h00, 6'h00, 32'hABCD});
    steps.push_back(step_t'{OP_CHECK,  SEL_STATUS, 8'h00, 6'h00, 6'h00, 32'h30});
    steps.push_back(step_t'{OP_READ,   14'd0,      8'h00, 6'h00, 6'h00, 32'hC1});
    steps.push_back(step_t'{OP_STATUS, 14'd0,      8'h00, 6'h00, 6'h30, 32'h00});
    steps.push_back(step_t'{OP_CHECK,  SEL_STATUS, 8'h00, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_READ,   14'd0,      8'h00, 6'h00, 6'h00, 32'h01});
    steps.push_back(step_t'{OP_STATUS, 14'd0,      8'h00, 6'h0E, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_READ,   14'd0,      8'h00, 6'h00, 6'h00, 32'h39});
    // Volume write and latch pulse
    steps.push_back(step_t'{OP_WRITE,  14'd6,      8'h5A, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_CHECK,  SEL_VOLUME, 8'h00, 6'h00, 6'h00, 32'h5A});
    steps.push_back(step_t'{OP_CHECK,  SEL_PULSES, 8'h00, 6'h00, 6'h00, 32'h01});
    steps.push_back(step_t'{OP_CHECK,  SEL_LATCH,  8'h00, 6'h00, 6'h00, 32'h00});
    // Control write ignored while audio is busy
    steps.push_back(step_t'{OP_STATUS, 14'd0,      8'h00, 6'h20, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_READ,   14'd0,      8'h00, 6'h00, 6'h00, 32'h79});
    steps.push_back(step_t'{OP_WRITE,  14'd7,      8'h03, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_CHECK,  SEL_STATUS, 8'h00, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_STATUS, 14'd0,      8'h00, 6'h00, 6'h20, 32'h00});
    steps.push_back(step_t'{OP_WRITE,  14'd7,      8'h03, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_CHECK,  SEL_STATUS, 8'h00, 6'h00, 6'h00, 32'h07});
    // Data port with pointer wrap
    steps.push_back(step_t'{OP_FILL,   14'h3FF8,   8'd8,  6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_FILL,   14'h0000,   8'd8,  6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_LOAD,   14'h3FFE,   8'h00, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_CHECK,  SEL_STATUS, 8'h00, 6'h00, 6'h00, 32'h47});
    steps.push_back(step_t'{OP_READ,   14'd1,      8'h00, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_READ,   14'd1,      8'h00, 6'h00, 6'h00, 32'h00});
    steps.push_back(step_t'{OP_CHECK,  SEL_STATUS, 8'h00, 6'h00, 6'h00, 32'h07});
    steps.push_back(step_t'{OP_READ,   14'd1,      8'h00, 6'h00, 6'h00, 32'h00});
    // ID string
    steps.push_back(step_t'{OP_READ,   14'd2,      8'h00, 6'h00, 6'h00, 32'h53});
    steps.push_back(step_t'{OP_READ,   14'd3,      8'h00, 6'h00, 6'h00, 32'h2D});
    steps.push_back(step_t'{OP_READ,   14'd4,      8'h00, 6'h00, 6'h00, 32'h4D});
    steps.push_back(step_t'{OP_READ,   14'd5,      8'h00, 6'h00, 6'h00, 32'h53});
    steps.push_back(step_t'{OP_READ,   14'd6,      8'h00, 6'h00, 6'h00, 32'h55});
    steps.push_back(step_t'{OP_READ,   14'd7,      8'h00, 6'h00, 6'h00, 32'h31});
  endtask

  task automatic run_step(input step_t s);
    logic [7:0] got;
    logic [7:0] want;
    case (s.op)
      OP_WRITE:  cpu_write(s.index[2:0], s.data);
      OP_READ: begin
        // Data reads return the byte before the pointer increment
        if (s.index[2:0] == MSU_REG_DATA) begin
          want      = buf_model[model_ptr];
          model_ptr = model_ptr + 14'd1;
        end else begin
          want = s.expected[7:0];
        end
        cpu_read(s.index[2:0], got);
        check_byte($sformatf("reg_data_out at register %0d", s.index), want, got);
      end
      OP_STATUS: status_update(s.set_mask, s.reset_mask);
      OP_LOAD: begin
        pointer_load(s.index);
        model_ptr = s.index;
      end
      OP_FILL:   buffer_fill(s.index, s.data);
      OP_CHECK: begin
        case (s.index)
          SEL_STATUS: check_status("status_out", s.expected[MSU_STATUS_OUT_W-1:0], status_out);
          SEL_ADDR:   check_seek("addr_out", s.expected[MSU_SEEK_W-1:0], addr_out);
          SEL_TRACK:  check_track("track_out", s.expected[MSU_TRACK_W-1:0], track_out);
          SEL_VOLUME: check_byte("volume_out", s.expected[7:0], volume_out);
          SEL_LATCH:  check_byte("volume_latch_out", s.expected[7:0], {7'b0, volume_latch_out});
          SEL_PULSES: check_byte("volume_latch_out pulses", s.expected[7:0], latch_pulses);
          default: begin
            $display("The stimulus table names an output selector that does not exist");
            abort_run();
          end
        endcase
      end
      default: begin
        $display("The stimulus table holds an unknown operation");
        abort_run();
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed                  = 32'h80928bd8;
    rst                   = 1'b1;
    enable                = 1'b1;
    reg_addr              = 3'd0;
    reg_data_in           = 8'h00;
    reg_oe                = 1'b0;
    reg_we                = 1'b0;
    pgm_address           = '0;
    pgm_data              = 8'h00;
    pgm_we                = 1'b1;
    status_set_bits       = '0;
    status_reset_bits     = '0;
    status_reset_we       = 1'b0;
    msu_address_ext       = '0;
    msu_address_ext_write = 1'b0;
    build_table();
    table_ready = 1'b1;
    wait_cycles(RESET_CYCLES);
    rst = 1'b0;
    wait_cycles(SETTLE_CYCLES);
    foreach (steps[k]) begin
      run_step(steps[k]);
    end
    $display("Verification passed");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    repeat (steps.size() * STEP_CYCLES + RESET_CYCLES + SETTLE_CYCLES) @(posedge clkin);
    $display("Timeout: the stimulus table did not finish within its cycle budget");
    abort_run();
  end

endmodule

// File: compile.f
+incdir+tb
design/msu_pkg.sv
design/msu_bus_sync.sv
design/msu_databuf.sv
design/msu_regs.sv
design/msu_top.sv
tb/msu_tb.sv

// File: Makefile
VERILATOR = verilator
TOP       = msu_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
VFLAGS    = --binary --timing --timescale 1ns/1ns -j 0 --Mdir $(BUILD_DIR)
LINTFLAGS = --lint-only --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
